/* residuPkg.sv */
`default_nettype none

package residuPkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and word types
	////////////////////////////////////////////////////////////////////////////

	// Each memory holds 2048 words
	parameter int addrWidth = 11;

	typedef logic [addrWidth-1:0] addr_t;
	// Speech sample, Q12 coefficient or output word
	typedef logic signed [15:0] sample_t;
	typedef logic signed [31:0] acc_t;
	// Frame length lg, 1 to 40
	typedef logic [5:0] frameLen_t;

	////////////////////////////////////////////////////////////////////////////
	// Pipeline stage records
	////////////////////////////////////////////////////////////////////////////

	// Tag riding alongside one tap read
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
		logic lastOfFrame;
		addr_t resultAddr;
	} tapCmd_t;

	// One finished sum out of the MAC
	typedef struct packed {
		logic valid;
		logic lastOfFrame;
		acc_t sum;
		addr_t resultAddr;
	} macOut_t;

	// Write into the result memory
	typedef struct packed {
		logic en;
		addr_t addr;
		sample_t data;
	} resultWr_t;

	// Sequencer states
	typedef enum logic [1:0] {idle, run, drain} seqState_t;

endpackage

`default_nettype wire

/* residuMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module residuMemory (
	input  wire logic              clk,
	// Write port
	input  wire logic              wrEn,
	input  wire residuPkg::addr_t  wrAddr,
	input  wire residuPkg::sample_t wrData,
	// Read port, data one cycle after address
	input  wire residuPkg::addr_t  rdAddr,
	output residuPkg::sample_t     rdData
);

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	// Full address space, 2048 words
	localparam int depth = 2 ** residuPkg::addrWidth;

	// Contents left uninitialized
	residuPkg::sample_t mem [0:depth-1];

	////////////////////////////////////////////////////////////////////////////
	// Ports
	////////////////////////////////////////////////////////////////////////////

	// Single write port
	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			mem[wrAddr] <= wrData;
		end
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge clk)
	begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

/* residuSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module residuSequencer #(
	parameter int lpcOrder = 10
) (
	input  wire logic                clk,
	input  wire logic                rst,
	// Frame control
	input  wire logic                start,
	input  wire residuPkg::frameLen_t lg,
	input  wire residuPkg::addr_t    coefBase,
	input  wire residuPkg::addr_t    sampleBase,
	input  wire residuPkg::addr_t    resultBase,
	input  wire logic                done,
	// Tap reads and their tag
	output residuPkg::addr_t         coefRdAddr,
	output residuPkg::addr_t         sampleRdAddr,
	output residuPkg::tapCmd_t       tap,
	output logic                     busy
);

	// Tap counter runs 0 to lpcOrder
	localparam int tapWidth = (lpcOrder > 0) ? $clog2(lpcOrder + 1) : 1;
	localparam logic [tapWidth-1:0] lastTap = tapWidth'(lpcOrder);

	residuPkg::seqState_t state;
	residuPkg::frameLen_t lgQ;
	residuPkg::frameLen_t outCnt;
	residuPkg::addr_t coefBaseQ;
	residuPkg::addr_t sampleBaseQ;
	residuPkg::addr_t resultBaseQ;
	logic [tapWidth-1:0] tapCnt;
	// Tag for the read issued this cycle
	residuPkg::tapCmd_t issueTag;
	logic tapIsLast;
	logic outIsLast;

	assign tapIsLast = tapCnt == lastTap;
	assign outIsLast = outCnt == lgQ - residuPkg::frameLen_t'(1);
	assign busy = state != residuPkg::idle;

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= residuPkg::idle;
			outCnt <= '0;
			tapCnt <= '0;
		end
		else
		begin
			case (state)
				residuPkg::idle:
				begin
					// Start while busy never reaches here
					if (start)
					begin
						state <= residuPkg::run;
						outCnt <= '0;
						tapCnt <= '0;
					end
				end
				residuPkg::run:
				begin
					// One tap per cycle, no gaps between outputs
					if (tapIsLast)
					begin
						tapCnt <= '0;
						outCnt <= outCnt + residuPkg::frameLen_t'(1);
						if (outIsLast)
						begin
							state <= residuPkg::drain;
						end
					end
					else
					begin
						tapCnt <= tapCnt + tapWidth'(1);
					end
				end
				residuPkg::drain:
				begin
					// Wait for the last result write
					if (done)
					begin
						state <= residuPkg::idle;
					end
				end
				default:
				begin
					state <= residuPkg::idle;
				end
			endcase
		end
	end

	// Frame setup captured on an accepted start
	always_ff @(posedge clk)
	begin
		if (state == residuPkg::idle && start)
		begin
			lgQ <= lg;
			coefBaseQ <= coefBase;
			sampleBaseQ <= sampleBase;
			resultBaseQ <= resultBase;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Issue stage and tag alignment
	////////////////////////////////////////////////////////////////////////////

	// coef at base+j, sample at base+n-j
	always_ff @(posedge clk)
	begin
		coefRdAddr <= coefBaseQ + residuPkg::addr_t'(tapCnt);
		sampleRdAddr <= sampleBaseQ + residuPkg::addr_t'(outCnt) - residuPkg::addr_t'(tapCnt);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			issueTag <= '0;
			tap <= '0;
		end
		else
		begin
			issueTag.valid <= state == residuPkg::run;
			issueTag.first <= tapCnt == '0;
			issueTag.last <= tapIsLast;
			issueTag.lastOfFrame <= tapIsLast && outIsLast;
			issueTag.resultAddr <= resultBaseQ + residuPkg::addr_t'(outCnt);
			// Second register lines up with RAM read data
			tap <= issueTag;
		end
	end

	// Pipeline empty once back in idle
	idleNoTag: assert property (@(posedge clk) disable iff (rst)
		state == residuPkg::idle |-> !tap.valid);

	// Done arrives only in drain, so busy covers the whole frame
	drainBusy: assert property (@(posedge clk) disable iff (rst)
		done |-> state == residuPkg::drain);

endmodule

`default_nettype wire

/* residuMac.sv */
`timescale 1ns/1ps
`default_nettype none

module residuMac (
	input  wire logic               clk,
	input  wire logic               rst,
	// Aligned tap from the memories
	input  wire residuPkg::tapCmd_t tap,
	input  wire residuPkg::sample_t coef,
	input  wire residuPkg::sample_t sample,
	// Finished sum, one cycle after the last tap
	output residuPkg::macOut_t      result
);

	residuPkg::acc_t product;
	residuPkg::acc_t doubled;
	residuPkg::acc_t base;
	residuPkg::acc_t satSum;
	residuPkg::acc_t acc;
	// One guard bit for overflow detection
	logic signed [32:0] wideSum;

	residuPkg::acc_t resultSum;
	residuPkg::addr_t resultAddrQ;
	logic resultValid;
	logic resultLast;

	////////////////////////////////////////////////////////////////////////////
	// L_mac datapath
	////////////////////////////////////////////////////////////////////////////

	// 16x16 signed product fits in 32 bits
	assign product = coef * sample;

	// Doubling overflows only for -32768 * -32768
	assign doubled = (product == 32'sh4000_0000) ? 32'sh7FFF_FFFF : product <<< 1;

	// Fresh sum on the first tap of an output
	assign base = tap.first ? '0 : acc;
	assign wideSum = {base[31], base} + {doubled[31], doubled};

	// Clip to 32 bits
	always_comb
	begin
		if (wideSum[32] != wideSum[31])
		begin
			satSum = wideSum[32] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
		end
		else
		begin
			satSum = wideSum[31:0];
		end
	end

	// Running sum
	always_ff @(posedge clk)
	begin
		if (tap.valid)
		begin
			acc <= satSum;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resultValid <= 1'b0;
			resultLast <= 1'b0;
		end
		else
		begin
			resultValid <= tap.valid && tap.last;
			resultLast <= tap.valid && tap.last && tap.lastOfFrame;
		end
	end

	always_ff @(posedge clk)
	begin
		resultSum <= satSum;
		resultAddrQ <= tap.resultAddr;
	end

	assign result = '{valid: resultValid, lastOfFrame: resultLast, sum: resultSum,
		resultAddr: resultAddrQ};

	// Taps of one output are never interleaved with another output
	firstUntilLast: assert property (@(posedge clk) disable iff (rst)
		(tap.valid && tap.first && !tap.last) |=>
		(!(tap.valid && tap.first) until_with (tap.valid && tap.last)));

endmodule

`default_nettype wire

/* residuRound.sv */
`timescale 1ns/1ps
`default_nettype none

module residuRound (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire residuPkg::macOut_t result,
	// Result memory write, done with the frame's last word
	output residuPkg::resultWr_t    wr,
	output logic                    done
);

	residuPkg::acc_t shifted;
	residuPkg::acc_t rounded;
	logic signed [32:0] wideRound;
	logic wrEn;
	residuPkg::addr_t wrAddr;
	residuPkg::sample_t wrData;

	////////////////////////////////////////////////////////////////////////////
	// L_shl by 3, then round to the high half
	////////////////////////////////////////////////////////////////////////////

	// Top four bits must agree for the shift to fit
	always_comb
	begin
		if (!result.sum[31] && (|result.sum[30:28]))
		begin
			shifted = 32'sh7FFF_FFFF;
		end
		else if (result.sum[31] && !(&result.sum[30:28]))
		begin
			shifted = 32'sh8000_0000;
		end
		else
		begin
			shifted = result.sum <<< 3;
		end
	end

	// Adding 0x8000 can only overflow upward
	assign wideRound = {shifted[31], shifted} + 33'sh0_0000_8000;
	assign rounded = (wideRound[32] != wideRound[31]) ? 32'sh7FFF_FFFF : wideRound[31:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrEn <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			wrEn <= result.valid;
			// Frame end flag from the MAC
			done <= result.lastOfFrame;
		end
	end

	// Address and word need no reset
	always_ff @(posedge clk)
	begin
		wrAddr <= result.resultAddr;
		wrData <= rounded[31:16];
	end

	assign wr = '{en: wrEn, addr: wrAddr, data: wrData};

	// MAC marks the frame end only on a valid sum
	doneWithWrite: assert property (@(posedge clk) disable iff (rst) done |-> wr.en);

endmodule

`default_nettype wire

/* residuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module residuTop #(
	parameter int lpcOrder = 10
) (
	input  wire logic                clk,
	input  wire logic                rst,
	// Coefficient preload
	input  wire logic                coefWrEn,
	input  wire residuPkg::addr_t    coefWrAddr,
	input  wire residuPkg::sample_t  coefWrData,
	// Sample preload, history below sampleBase
	input  wire logic                sampleWrEn,
	input  wire residuPkg::addr_t    sampleWrAddr,
	input  wire residuPkg::sample_t  sampleWrData,
	// Frame setup, stable while busy
	input  wire residuPkg::addr_t    coefBase,
	input  wire residuPkg::addr_t    sampleBase,
	input  wire residuPkg::addr_t    resultBase,
	input  wire residuPkg::frameLen_t lg,
	// Control
	input  wire logic                start,
	output logic                     busy,
	output logic                     done,
	// Readback
	input  wire residuPkg::addr_t    resultRdAddr,
	output residuPkg::sample_t       resultRdData
);

	residuPkg::addr_t coefRdAddr;
	residuPkg::addr_t sampleRdAddr;
	residuPkg::sample_t coefRdData;
	residuPkg::sample_t sampleRdData;
	residuPkg::tapCmd_t tap;
	residuPkg::macOut_t macResult;
	residuPkg::resultWr_t resultWr;

	////////////////////////////////////////////////////////////////////////////
	// Memories
	////////////////////////////////////////////////////////////////////////////

	residuMemory coefMem (.clk(clk), .wrEn(coefWrEn), .wrAddr(coefWrAddr),
		.wrData(coefWrData), .rdAddr(coefRdAddr), .rdData(coefRdData));

	residuMemory sampleMem (.clk(clk), .wrEn(sampleWrEn), .wrAddr(sampleWrAddr),
		.wrData(sampleWrData), .rdAddr(sampleRdAddr), .rdData(sampleRdData));

	// Written by the round stage, read by the host
	residuMemory resultMem (.clk(clk), .wrEn(resultWr.en), .wrAddr(resultWr.addr),
		.wrData(resultWr.data), .rdAddr(resultRdAddr), .rdData(resultRdData));

	////////////////////////////////////////////////////////////////////////////
	// Filter pipeline
	////////////////////////////////////////////////////////////////////////////

	residuSequencer #(.lpcOrder(lpcOrder)) sequencer (.clk(clk), .rst(rst), .start(start),
		.lg(lg), .coefBase(coefBase), .sampleBase(sampleBase), .resultBase(resultBase),
		.done(done), .coefRdAddr(coefRdAddr), .sampleRdAddr(sampleRdAddr), .tap(tap),
		.busy(busy));

	// Tag already aligned with the read data
	residuMac mac (.clk(clk), .rst(rst), .tap(tap), .coef(coefRdData),
		.sample(sampleRdData), .result(macResult));

	residuRound round (.clk(clk), .rst(rst), .result(macResult), .wr(resultWr),
		.done(done));

endmodule

`default_nettype wire

/* residuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module residuTb;

	localparam int lpcOrder = 10;
	localparam int taps = lpcOrder + 1;
	// Longest frame plus pipeline slack
	localparam int waitLimit = 40 * taps + 20;
	localparam longint maxAcc = 64'sd2147483647;
	localparam longint minAcc = -64'sd2147483648;

	// One expected result word
	typedef struct packed {
		residuPkg::addr_t addr;
		residuPkg::sample_t data;
	} expect_t;

	logic clk;
	logic rst;
	logic coefWrEn;
	residuPkg::addr_t coefWrAddr;
	residuPkg::sample_t coefWrData;
	logic sampleWrEn;
	residuPkg::addr_t sampleWrAddr;
	residuPkg::sample_t sampleWrData;
	residuPkg::addr_t coefBase;
	residuPkg::addr_t sampleBase;
	residuPkg::addr_t resultBase;
	residuPkg::frameLen_t lg;
	logic start;
	logic busy;
	logic done;
	residuPkg::addr_t resultRdAddr;
	residuPkg::sample_t resultRdData;

	int cycleCount = 0;
	int checkCount = 0;
	int compareErrors = 0;
	int assertErrors = 0;
	int timeouts = 0;

	// Host-side copies of what the memories should hold
	residuPkg::sample_t coefShadow [0:2047];
	residuPkg::sample_t sampleShadow [0:2047];
	residuPkg::sample_t resultShadow [0:2047];
	expect_t expectQ [$];

	residuTop #(.lpcOrder(lpcOrder)) residuTop_inst (.clk(clk), .rst(rst),
		.coefWrEn(coefWrEn), .coefWrAddr(coefWrAddr), .coefWrData(coefWrData),
		.sampleWrEn(sampleWrEn), .sampleWrAddr(sampleWrAddr), .sampleWrData(sampleWrData),
		.coefBase(coefBase), .sampleBase(sampleBase), .resultBase(resultBase), .lg(lg),
		.start(start), .busy(busy), .done(done), .resultRdAddr(resultRdAddr),
		.resultRdData(resultRdData));

	// 40 ns clock
	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic longint clip32(input longint v);
		if (v > maxAcc)
		begin
			return maxAcc;
		end
		if (v < minAcc)
		begin
			return minAcc;
		end
		return v;
	endfunction

	// y[n] = sum of a[j] x[n-j], L_mac then L_shl 3 and round
	function automatic residuPkg::sample_t expectedOut(input residuPkg::addr_t cBase,
		input residuPkg::addr_t sBase, input int n);
		longint acc;
		longint prod;
		residuPkg::addr_t sAddr;
		acc = 0;
		for (int j = 0; j < taps; j++)
		begin
			sAddr = sBase + residuPkg::addr_t'(n) - residuPkg::addr_t'(j);
			prod = clip32(2 * longint'(coefShadow[cBase + residuPkg::addr_t'(j)])
				* longint'(sampleShadow[sAddr]));
			acc = clip32(acc + prod);
		end
		acc = clip32(acc * 8);
		acc = clip32(acc + 32768);
		return residuPkg::sample_t'(acc >>> 16);
	endfunction

	// Marker depends on every address bit
	function automatic residuPkg::sample_t markerWord(input residuPkg::addr_t addr);
		return {5'b10110, addr};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Host tasks, each entered and left 2 ns after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic writeCoef(input residuPkg::addr_t addr, input residuPkg::sample_t data);
		coefWrEn = 1'b1;
		coefWrAddr = addr;
		coefWrData = data;
		coefShadow[addr] = data;
		@(posedge clk);
		#2;
		coefWrEn = 1'b0;
	endtask

	task automatic writeSample(input residuPkg::addr_t addr, input residuPkg::sample_t data);
		sampleWrEn = 1'b1;
		sampleWrAddr = addr;
		sampleWrData = data;
		sampleShadow[addr] = data;
		@(posedge clk);
		#2;
		sampleWrEn = 1'b0;
	endtask

	task automatic checkWord(input string name, input residuPkg::sample_t expected,
		input residuPkg::sample_t actual);
		checkCount++;
		assert (expected === actual)
		else
		begin
			compareErrors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkValue(input string name, input int expected, input int actual);
		checkCount++;
		assert (expected == actual)
		else
		begin
			compareErrors++;
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// Read data comes one cycle after the address
	task automatic readWord(input residuPkg::addr_t addr, output residuPkg::sample_t data);
		resultRdAddr = addr;
		@(posedge clk);
		#1;
		data = resultRdData;
		#1;
	endtask

	// Queue the model outputs, start, wait for done and then for idle
	task automatic runFrame(input string name, input residuPkg::addr_t cBase,
		input residuPkg::addr_t sBase, input residuPkg::addr_t rBase, input int len,
		input bit extraStart);
		int t0;
		int waited;
		expect_t entry;
		for (int n = 0; n < len; n++)
		begin
			entry.addr = rBase + residuPkg::addr_t'(n);
			entry.data = expectedOut(cBase, sBase, n);
			expectQ.push_back(entry);
			resultShadow[entry.addr] = entry.data;
		end
		coefBase = cBase;
		sampleBase = sBase;
		resultBase = rBase;
		lg = residuPkg::frameLen_t'(len);
		start = 1'b1;
		t0 = cycleCount;
		@(posedge clk);
		#1;
		checkValue($sformatf("%s busy rise", name), 1, busy);
		#1;
		start = 1'b0;
		// Stray start mid-frame must be ignored
		if (extraStart)
		begin
			repeat (5) @(posedge clk);
			#2;
			start = 1'b1;
			@(posedge clk);
			#2;
			start = 1'b0;
		end
		waited = 0;
		while (done !== 1'b1 && waited < waitLimit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (done !== 1'b1)
		begin
			timeouts++;
			$display("Timeout: frame %s never raised done", name);
		end
		else
		begin
			checkValue($sformatf("%s done latency", name), len * taps + 4, cycleCount - t0);
		end
		waited = 0;
		while (busy !== 1'b0 && waited < 4)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (busy !== 1'b0)
		begin
			timeouts++;
			$display("Timeout: busy stayed high after frame %s", name);
		end
		#1;
	endtask

	// Drain the expected queue against readback
	task automatic checkResults(input string name);
		expect_t entry;
		residuPkg::sample_t data;
		while (expectQ.size() > 0)
		begin
			entry = expectQ.pop_front();
			readWord(entry.addr, data);
			checkWord($sformatf("%s at %0d", name, entry.addr), entry.data, data);
		end
	endtask

	task automatic checkUntouched(input string name, input residuPkg::addr_t addr);
		residuPkg::sample_t data;
		readWord(addr, data);
		checkWord($sformatf("%s untouched at %0d", name, addr), resultShadow[addr], data);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Control protocol checks
	////////////////////////////////////////////////////////////////////////////

	resetQuiet: assert property (@(posedge clk) $fell(rst) |-> (!busy && !done))
	else
	begin
		assertErrors++;
		$display("Error: busy or done high right after reset");
	end

	donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
	begin
		assertErrors++;
		$display("Error: done stayed high for more than one cycle");
	end

	doneBusy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
	else
	begin
		assertErrors++;
		$display("Error: done pulsed while not busy");
	end

	busyFall: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
	else
	begin
		assertErrors++;
		$display("Error: busy did not fall after done");
	end

	busyRise: assert property (@(posedge clk) disable iff (rst) (start && !busy) |=> busy)
	else
	begin
		assertErrors++;
		$display("Error: busy did not rise after an idle start");
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		coefWrEn = 1'b0;
		coefWrAddr = '0;
		coefWrData = '0;
		sampleWrEn = 1'b0;
		sampleWrAddr = '0;
		sampleWrData = '0;
		coefBase = '0;
		sampleBase = '0;
		resultBase = '0;
		lg = '0;
		start = 1'b0;
		resultRdAddr = '0;
		void'($urandom(87));
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		checkValue("reset busy", 0, busy);
		checkValue("reset done", 0, done);

		// Identity filter copies markers into results 200 to 239
		for (int j = 0; j < taps; j++)
		begin
			writeCoef(residuPkg::addr_t'(1000 + j), (j == 0) ? 16'sd4096 : 16'sd0);
		end
		for (int a = 990; a < 1040; a++)
		begin
			writeSample(residuPkg::addr_t'(a), markerWord(residuPkg::addr_t'(a)));
		end
		runFrame("marker", 1000, 1000, 200, 40, 1'b0);
		checkResults("marker");

		// Random frame, small Q12 taps
		for (int j = 0; j < taps; j++)
		begin
			writeCoef(residuPkg::addr_t'(40 + j),
				residuPkg::sample_t'($urandom_range(4095, 0) - 2048));
		end
		for (int a = 6; a < 56; a++)
		begin
			writeSample(residuPkg::addr_t'(a),
				residuPkg::sample_t'($urandom_range(16383, 0) - 8192));
		end
		runFrame("random", 40, 16, 300, 40, 1'b0);
		checkResults("random");

		// Full-scale taps hit accumulator clipping, single tap hits shift clipping
		for (int j = 0; j < taps; j++)
		begin
			writeCoef(residuPkg::addr_t'(500 + j), 16'sh7FFF);
			writeCoef(residuPkg::addr_t'(520 + j), (j == 0) ? 16'sh7FFF : 16'sh0000);
		end
		for (int a = 590; a < 610; a++)
		begin
			writeSample(residuPkg::addr_t'(a), ((a / 4) % 2 == 1) ? 16'sh8000 : 16'sh7FFF);
		end
		runFrame("saturation acc", 500, 600, 400, 8, 1'b0);
		runFrame("saturation shift", 520, 600, 420, 8, 1'b0);
		checkResults("saturation");

		// Short frames inside the marker region
		runFrame("lg17", 40, 30, 205, 17, 1'b1);
		checkResults("lg17");
		checkUntouched("lg17", 204);
		checkUntouched("lg17", 222);
		runFrame("lg1", 500, 605, 230, 1, 1'b0);
		checkResults("lg1");
		checkUntouched("lg1", 229);
		checkUntouched("lg1", 231);

		// Second frame reuses the tail of the first as history
		for (int a = 690; a < 780; a++)
		begin
			writeSample(residuPkg::addr_t'(a),
				residuPkg::sample_t'($urandom_range(16383, 0) - 8192));
		end
		runFrame("back to back first", 40, 700, 600, 40, 1'b0);
		runFrame("back to back second", 40, 740, 640, 40, 1'b0);
		checkResults("back to back");

		$display("checks %0d, compare errors %0d, assertion errors %0d, timeouts %0d",
			checkCount, compareErrors, assertErrors, timeouts);
		if (compareErrors + assertErrors + timeouts == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
residuPkg.sv
residuMemory.sv
residuSequencer.sv
residuMac.sv
residuRound.sv
residuTop.sv
residuTb.sv
